// ==== source/sorter_pkg.sv ====
`default_nettype none

package sorter_pkg;

    // one record, ordered by key only
    typedef struct packed {
        logic [15:0] key;
        logic [15:0] value;
    } tuple_t;

    // one bank row, even half in the low bits
    typedef struct packed {
        tuple_t odd;
        tuple_t even;
    } tuple_pair_t;

    typedef enum logic [1:0] {
        PHASE_LOAD,
        PHASE_SORT,
        PHASE_MERGE,
        PHASE_DRAIN
    } phase_t;

    typedef enum logic {
        PING,
        PONG
    } bank_t;

endpackage

`default_nettype wire

// ==== source/pair_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module pair_bank
    import sorter_pkg::*;
#(
    parameter int N_ROWS = 8,
    localparam int ADDR_W = $clog2(N_ROWS)
) (
    input  logic              clock,
    input  logic [ADDR_W-1:0] row_addr,
    input  logic              read_en,
    input  logic              write_en,
    input  tuple_pair_t       write_data,
    output tuple_pair_t       read_data
);

    tuple_pair_t rows [N_ROWS];

    // reads and writes never share a cycle
    always_ff @(posedge clock) begin
        if (write_en) begin
            rows[row_addr] <= write_data;
        end
        // output holds between reads
        if (read_en) begin
            read_data <= rows[row_addr];
        end
    end

endmodule

`default_nettype wire

// ==== source/pair_sort_phase.sv ====
`timescale 1ns/1ps
`default_nettype none

module pair_sort_phase
    import sorter_pkg::*;
#(
    parameter int N_ROWS = 8,
    localparam int ADDR_W = $clog2(N_ROWS)
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              en,
    output logic [ADDR_W-1:0] ping_addr,
    output logic              ping_read_en,
    input  tuple_pair_t       ping_data,
    output logic [ADDR_W-1:0] pong_addr,
    output logic              pong_write_en,
    output tuple_pair_t       pong_data,
    output logic              done
);

    localparam logic [ADDR_W-1:0] LAST_ROW = ADDR_W'(N_ROWS - 1);

    logic              started;
    logic              reading;
    logic [ADDR_W-1:0] rd_cnt;
    logic              ret_valid;
    logic [ADDR_W-1:0] ret_addr;
    logic              swap;

    assign ping_addr    = rd_cnt;
    assign ping_read_en = reading;

    // strict compare keeps equal keys in arrival order
    assign swap = ping_data.odd.key < ping_data.even.key;

    always_ff @(posedge clock) begin
        if (reset) begin
            started       <= 1'b0;
            reading       <= 1'b0;
            rd_cnt        <= '0;
            ret_valid     <= 1'b0;
            pong_write_en <= 1'b0;
            done          <= 1'b0;
        end else begin
            ret_valid     <= reading;
            pong_write_en <= ret_valid;
            done          <= pong_write_en && pong_addr == LAST_ROW;
            if (!en) begin
                started <= 1'b0;
            end else if (!started) begin
                started <= 1'b1;
                reading <= 1'b1;
                rd_cnt  <= '0;
            end
            if (reading) begin
                rd_cnt <= rd_cnt + 1'b1;
                if (rd_cnt == LAST_ROW) begin
                    reading <= 1'b0;
                end
            end
        end
    end

    // row address follows the bank latency
    always_ff @(posedge clock) begin
        ret_addr  <= rd_cnt;
        pong_addr <= ret_addr;
        pong_data <= swap ? tuple_pair_t'{even: ping_data.odd, odd: ping_data.even}
                          : ping_data;
    end

endmodule

`default_nettype wire

// ==== source/run_merge_phase.sv ====
`timescale 1ns/1ps
`default_nettype none

module run_merge_phase
    import sorter_pkg::*;
#(
    parameter int N_ROWS = 8,
    localparam int ADDR_W = $clog2(N_ROWS)
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              en,
    output logic [ADDR_W-1:0] read_addr,
    output logic              read_en,
    input  tuple_pair_t       read_data,
    output logic [ADDR_W-1:0] write_addr,
    output logic              write_en,
    output tuple_pair_t       write_data,
    output bank_t             source,
    output logic              done
);

    localparam logic [ADDR_W:0] ROWS = (ADDR_W + 1)'(N_ROWS);

    typedef enum logic [1:0] {M_IDLE, M_SETUP, M_RUN, M_DONE} merge_state_t;

    merge_state_t      state;
    logic [ADDR_W:0]   run_rows;
    logic [ADDR_W:0]   base;
    logic [ADDR_W:0]   next_base;
    tuple_pair_t       l_buf;
    tuple_pair_t       r_buf;
    logic              l_hv;
    logic              r_hv;
    logic              l_slot;
    logic              r_slot;
    logic [ADDR_W:0]   l_left;
    logic [ADDR_W:0]   r_left;
    logic [ADDR_W-1:0] l_addr;
    logic [ADDR_W-1:0] r_addr;
    logic              pend;
    logic              pend_right;
    tuple_t            out_even;
    logic              out_half;
    logic [ADDR_W-1:0] wr_ptr;
    tuple_t            l_head;
    tuple_t            r_head;
    tuple_t            emit;
    logic              l_need;
    logic              r_need;
    logic              l_exh;
    logic              r_exh;
    logic              take_l;
    logic              take_r;

    assign l_head    = l_slot ? l_buf.odd : l_buf.even;
    assign r_head    = r_slot ? r_buf.odd : r_buf.even;
    assign next_base = base + (run_rows << 1);

    // refill only when the head row is used up
    assign l_need = !l_hv && l_left != '0;
    assign r_need = !r_hv && r_left != '0;
    assign l_exh  = !l_hv && l_left == '0 && !(pend && !pend_right);
    assign r_exh  = !r_hv && r_left == '0 && !(pend && pend_right);

    // left wins ties for stability
    assign take_l = state == M_RUN && l_hv &&
                    (r_exh || (r_hv && l_head.key <= r_head.key));
    assign take_r = state == M_RUN && r_hv && !take_l && (l_exh || l_hv);
    assign emit   = take_l ? l_head : r_head;

    assign read_en   = state == M_RUN && !pend && (l_need || r_need);
    assign read_addr = l_need ? l_addr : r_addr;

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= M_IDLE;
            source   <= PONG;
            done     <= 1'b0;
            write_en <= 1'b0;
            pend     <= 1'b0;
            l_hv     <= 1'b0;
            r_hv     <= 1'b0;
            out_half <= 1'b0;
        end else begin
            done     <= 1'b0;
            write_en <= 1'b0;
            case (state)
                M_IDLE: begin
                    if (en) begin
                        state    <= M_SETUP;
                        source   <= PONG;
                        run_rows <= 1;
                        base     <= '0;
                        wr_ptr   <= '0;
                    end
                end
                M_SETUP: begin
                    // load both runs of the next pair
                    state  <= M_RUN;
                    l_addr <= base[ADDR_W-1:0];
                    r_addr <= ADDR_W'(base + run_rows);
                    l_left <= run_rows;
                    r_left <= run_rows;
                    l_hv   <= 1'b0;
                    r_hv   <= 1'b0;
                end
                M_RUN: begin
                    if (read_en) begin
                        pend       <= 1'b1;
                        pend_right <= !l_need;
                        if (l_need) begin
                            l_addr <= l_addr + 1'b1;
                            l_left <= l_left - 1'b1;
                        end else begin
                            r_addr <= r_addr + 1'b1;
                            r_left <= r_left - 1'b1;
                        end
                    end
                    if (pend) begin
                        pend <= 1'b0;
                        if (pend_right) begin
                            r_buf  <= read_data;
                            r_hv   <= 1'b1;
                            r_slot <= 1'b0;
                        end else begin
                            l_buf  <= read_data;
                            l_hv   <= 1'b1;
                            l_slot <= 1'b0;
                        end
                    end
                    if (take_l) begin
                        l_slot <= 1'b1;
                        l_hv   <= !l_slot;
                    end
                    if (take_r) begin
                        r_slot <= 1'b1;
                        r_hv   <= !r_slot;
                    end
                    if (take_l || take_r) begin
                        out_half <= !out_half;
                        if (out_half) begin
                            write_en   <= 1'b1;
                            write_addr <= wr_ptr;
                            write_data <= '{odd: emit, even: out_even};
                            wr_ptr     <= wr_ptr + 1'b1;
                        end else begin
                            out_even <= emit;
                        end
                    end
                    if (l_exh && r_exh) begin
                        state <= M_SETUP;
                        base  <= next_base;
                        // pass complete
                        if (next_base == ROWS) begin
                            base     <= '0;
                            run_rows <= run_rows << 1;
                            source   <= source == PING ? PONG : PING;
                            if ((run_rows << 1) == ROWS) begin
                                state <= M_DONE;
                                done  <= 1'b1;
                            end
                        end
                    end
                end
                M_DONE: begin
                    if (!en) begin
                        state <= M_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/pingpong_sorter.sv ====
`timescale 1ns/1ps
`default_nettype none

module pingpong_sorter
    import sorter_pkg::*;
#(
    parameter int N_ROWS = 8
) (
    input  logic   clock,
    input  logic   reset,
    input  logic   in_req,
    input  tuple_t in_data,
    output logic   in_ack,
    output logic   out_req,
    output tuple_t out_data,
    input  logic   out_ack
);

    localparam int ADDR_W = $clog2(N_ROWS);

    typedef enum logic [1:0] {D_FETCH, D_SHOW, D_HOLD, D_RELEASE} drain_state_t;

    phase_t            phase;
    drain_state_t      d_state;
    logic [ADDR_W:0]   load_cnt;
    logic [ADDR_W:0]   drain_cnt;
    tuple_t            load_hold;
    logic              load_take;
    logic              drain_read;
    tuple_pair_t       drain_rdata;

    logic [ADDR_W-1:0] bank_addr [2];
    logic              bank_read [2];
    logic              bank_write [2];
    tuple_pair_t       bank_wdata [2];
    tuple_pair_t       bank_rdata [2];

    logic [ADDR_W-1:0] sort_raddr;
    logic              sort_read;
    logic [ADDR_W-1:0] sort_waddr;
    logic              sort_write;
    tuple_pair_t       sort_wdata;
    logic              sort_done;

    logic [ADDR_W-1:0] merge_raddr;
    logic              merge_read;
    logic [ADDR_W-1:0] merge_waddr;
    logic              merge_write;
    tuple_pair_t       merge_wdata;
    bank_t             merge_source;
    bank_t             merge_dest;
    logic              merge_done;

    assign load_take   = phase == PHASE_LOAD && in_req && !in_ack;
    assign drain_read  = phase == PHASE_DRAIN && d_state == D_FETCH;
    assign merge_dest  = merge_source == PING ? PONG : PING;
    // after the merge, source names the result bank
    assign drain_rdata = bank_rdata[merge_source];
    assign out_data    = drain_cnt[0] ? drain_rdata.odd : drain_rdata.even;

    // bank port owner per phase
    always_comb begin
        for (int b = 0; b < 2; b++) begin
            bank_addr[b]  = '0;
            bank_read[b]  = 1'b0;
            bank_write[b] = 1'b0;
            bank_wdata[b] = '0;
        end
        case (phase)
            PHASE_LOAD: begin
                bank_addr[PING]  = load_cnt[ADDR_W:1];
                bank_write[PING] = load_take && load_cnt[0];
                bank_wdata[PING] = '{odd: in_data, even: load_hold};
            end
            PHASE_SORT: begin
                bank_addr[PING]  = sort_raddr;
                bank_read[PING]  = sort_read;
                bank_addr[PONG]  = sort_waddr;
                bank_write[PONG] = sort_write;
                bank_wdata[PONG] = sort_wdata;
            end
            PHASE_MERGE: begin
                bank_addr[merge_source]  = merge_raddr;
                bank_read[merge_source]  = merge_read;
                bank_addr[merge_dest]    = merge_waddr;
                bank_write[merge_dest]   = merge_write;
                bank_wdata[merge_dest]   = merge_wdata;
            end
            PHASE_DRAIN: begin
                bank_addr[merge_source] = drain_cnt[ADDR_W:1];
                bank_read[merge_source] = drain_read;
            end
        endcase
    end

    pair_bank #(.N_ROWS(N_ROWS)) bank_ping (
        .clock(clock), .row_addr(bank_addr[PING]),
        .read_en(bank_read[PING]), .write_en(bank_write[PING]),
        .write_data(bank_wdata[PING]), .read_data(bank_rdata[PING])
    );

    pair_bank #(.N_ROWS(N_ROWS)) bank_pong (
        .clock(clock), .row_addr(bank_addr[PONG]),
        .read_en(bank_read[PONG]), .write_en(bank_write[PONG]),
        .write_data(bank_wdata[PONG]), .read_data(bank_rdata[PONG])
    );

    pair_sort_phase #(.N_ROWS(N_ROWS)) sort_phase (
        .clock(clock), .reset(reset), .en(phase == PHASE_SORT),
        .ping_addr(sort_raddr), .ping_read_en(sort_read), .ping_data(bank_rdata[PING]),
        .pong_addr(sort_waddr), .pong_write_en(sort_write), .pong_data(sort_wdata),
        .done(sort_done)
    );

    run_merge_phase #(.N_ROWS(N_ROWS)) merge_phase (
        .clock(clock), .reset(reset), .en(phase == PHASE_MERGE),
        .read_addr(merge_raddr), .read_en(merge_read),
        .read_data(bank_rdata[merge_source]),
        .write_addr(merge_waddr), .write_en(merge_write), .write_data(merge_wdata),
        .source(merge_source), .done(merge_done)
    );

    // even tuple waits here for its odd partner
    always_ff @(posedge clock) begin
        if (load_take && !load_cnt[0]) begin
            load_hold <= in_data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            phase     <= PHASE_LOAD;
            in_ack    <= 1'b0;
            out_req   <= 1'b0;
            load_cnt  <= '0;
            drain_cnt <= '0;
            d_state   <= D_FETCH;
        end else begin
            // ack may still be falling after the load phase ends
            if (load_take) begin
                in_ack   <= 1'b1;
                load_cnt <= load_cnt + 1'b1;
                if (&load_cnt) begin
                    phase <= PHASE_SORT;
                end
            end else if (in_ack && !in_req) begin
                in_ack <= 1'b0;
            end
            case (phase)
                PHASE_SORT: begin
                    if (sort_done) phase <= PHASE_MERGE;
                end
                PHASE_MERGE: begin
                    if (merge_done) phase <= PHASE_DRAIN;
                end
                PHASE_DRAIN: begin
                    case (d_state)
                        D_FETCH: d_state <= D_SHOW;
                        D_SHOW: begin
                            out_req <= 1'b1;
                            d_state <= D_HOLD;
                        end
                        D_HOLD: begin
                            if (out_ack) begin
                                out_req <= 1'b0;
                                d_state <= D_RELEASE;
                            end
                        end
                        D_RELEASE: begin
                            if (!out_ack) begin
                                drain_cnt <= drain_cnt + 1'b1;
                                // odd half done means a new row is needed
                                d_state   <= drain_cnt[0] ? D_FETCH : D_SHOW;
                                if (&drain_cnt) begin
                                    phase <= PHASE_LOAD;
                                end
                            end
                        end
                    endcase
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== test/sorter_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module sorter_chk
    import sorter_pkg::*;
(
    input logic   clock,
    input logic   reset,
    input logic   in_req,
    input logic   in_ack,
    input logic   out_req,
    input logic   out_ack,
    input tuple_t out_data
);

    // ack only answers a live request
    in_ack_needs_req: assert property (@(posedge clock) disable iff (reset)
        $rose(in_ack) |-> $past(in_req))
        else $error("in_ack rose without in_req");

    out_data_stable: assert property (@(posedge clock) disable iff (reset)
        out_req && !out_ack |=> $stable(out_data))
        else $error("out_data changed while waiting for out_ack");

    out_req_held: assert property (@(posedge clock) disable iff (reset)
        $fell(out_req) |-> $past(out_ack))
        else $error("out_req fell before out_ack");

    // request is low the cycle after reset
    out_req_reset: assert property (@(posedge clock)
        reset |=> !out_req)
        else $error("out_req high after reset");

endmodule

bind pingpong_sorter sorter_chk chk (
    .clock(clock), .reset(reset), .in_req(in_req), .in_ack(in_ack),
    .out_req(out_req), .out_ack(out_ack), .out_data(out_data)
);

`default_nettype wire

// ==== test/tb_sorter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sorter
    import sorter_pkg::*;
();

    localparam int N_ROWS     = 8;
    localparam int N_TUPLES   = 2 * N_ROWS;
    localparam int TIMEOUT_NS = 6 * N_TUPLES * 40 * 8;

    logic   clock;
    logic   reset;
    logic   in_req;
    tuple_t in_data;
    logic   in_ack;
    logic   out_req;
    tuple_t out_data;
    logic   out_ack;

    logic [31:0] rng_state;
    tuple_t      stim     [N_TUPLES];
    tuple_t      expected [N_TUPLES];
    tuple_t      got      [N_TUPLES];
    tuple_t      rand_set [N_TUPLES];

    pingpong_sorter #(.N_ROWS(N_ROWS)) dut (
        .clock(clock), .reset(reset),
        .in_req(in_req), .in_data(in_data), .in_ack(in_ack),
        .out_req(out_req), .out_data(out_data), .out_ack(out_ack)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    initial begin
        #(TIMEOUT_NS);
        abort_run("timeout: the sorter did not finish all tests in time");
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        if (act_val !== exp_val) begin
            abort_run($sformatf("[ERROR] %s expected 0x%h got 0x%h",
                                name, exp_val, act_val));
        end
    endtask

    // advance to just after the next rising edge
    task automatic step();
        @(posedge clock);
        #1;
    endtask

    task automatic sort_reference();
        tuple_t t;
        int     j;
        expected = stim;
        for (int i = 1; i < N_TUPLES; i++) begin
            t = expected[i];
            j = i - 1;
            // strict compare keeps earlier tuples first on equal keys
            while (j >= 0 && expected[j].key > t.key) begin
                expected[j + 1] = expected[j];
                j--;
            end
            expected[j + 1] = t;
        end
    endtask

    task automatic load_run();
        for (int i = 0; i < N_TUPLES; i++) begin
            in_data = stim[i];
            in_req  = 1'b1;
            do step(); while (!in_ack);
            in_req = 1'b0;
            do step(); while (in_ack);
        end
    endtask

    task automatic drain_run(input int ack_delay);
        for (int i = 0; i < N_TUPLES; i++) begin
            while (!out_req) step();
            got[i] = out_data;
            repeat (ack_delay) step();
            out_ack = 1'b1;
            while (out_req) step();
            out_ack = 1'b0;
        end
    endtask

    task automatic run_and_compare(input int ack_delay, input string label);
        sort_reference();
        load_run();
        drain_run(ack_delay);
        for (int i = 0; i < N_TUPLES; i++) begin
            check_value($sformatf("%s out_data[%0d]", label, i), expected[i], got[i]);
        end
    endtask

    task automatic test_reset_state();
        check_value("out_req", '0, 32'(out_req));
        check_value("in_ack", '0, 32'(in_ack));
    endtask

    task automatic test_ascending();
        for (int i = 0; i < N_TUPLES; i++) begin
            stim[i] = '{key: 16'(10 * i + 3), value: 16'(i)};
        end
        run_and_compare(0, "ascending");
    endtask

    // every row swaps and every pass merges
    task automatic test_descending();
        for (int i = 0; i < N_TUPLES; i++) begin
            stim[i] = '{key: 16'(60000 - 1000 * i), value: 16'(i)};
        end
        run_and_compare(0, "descending");
    endtask

    task automatic test_duplicates();
        for (int i = 0; i < N_TUPLES; i++) begin
            rng_state   = xorshift32(rng_state);
            rand_set[i] = '{key: 16'(rng_state[2:0]), value: 16'(i)};
        end
        stim = rand_set;
        run_and_compare(0, "duplicates");
    endtask

    task automatic test_slow_drain();
        stim = rand_set;
        run_and_compare(5, "slow drain");
    endtask

    task automatic test_back_to_back();
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < N_TUPLES; i++) begin
                rng_state = xorshift32(rng_state);
                stim[i].key   = (r == 0) ? rng_state[15:0] : 16'(rng_state[1:0]);
                stim[i].value = 16'(i);
            end
            run_and_compare(r + 1, $sformatf("back to back %0d", r));
        end
    endtask

    initial begin
        reset     = 1'b1;
        in_req    = 1'b0;
        in_data   = '0;
        out_ack   = 1'b0;
        rng_state = 32'hef484536;
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;
        test_reset_state();
        test_ascending();
        test_descending();
        test_duplicates();
        test_slow_drain();
        test_back_to_back();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/sorter_pkg.sv
source/pair_bank.sv
source/pair_sort_phase.sv
source/run_merge_phase.sv
source/pingpong_sorter.sv
test/sorter_chk.sv
test/tb_sorter.sv

// ==== run.sh ====
#!/bin/sh
# build and run the sorter testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module tb_sorter \
    -Mdir "$BUILD_DIR" -o tb_sorter
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"$BUILD_DIR/tb_sorter" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# the log decides pass or fail
if grep -qx "All tests passed" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1
